/* include/sc_macros.svh */
// Width, depth and counter size macros for the lockstep retirement checker
`ifndef SC_MACROS_SVH
`define SC_MACROS_SVH

// PC and write data width, the design assumes RV32
`define SC_XLEN 32

// Entries per retirement FIFO, also the credits each producer starts with
`define SC_FIFO_DEPTH 4

// Credit and fill counters must reach SC_FIFO_DEPTH itself
`define SC_CREDIT_W ($clog2(`SC_FIFO_DEPTH) + 1)

// Compared-instruction and exception counters
`define SC_CNT_W 16

`endif

/* source/sc_pkg.sv */
// Scheduler state and mismatch kind types shared by the checker and its testbench
package sc_pkg;

   // Step scheduler states
   typedef enum logic [2:0] {
      IDLE     = 3'd0,
      STEP_DUT = 3'd1,
      STEP_REF = 3'd2,
      COMPARE  = 3'd3,
      HALT     = 3'd4
   } sc_state_e;

   // First failing field, in compare priority order
   typedef enum logic [2:0] {
      MIS_NONE  = 3'd0,
      MIS_PC    = 3'd1,
      MIS_WE    = 3'd2,
      MIS_RD    = 3'd3,
      MIS_WDATA = 3'd4
   } sc_mis_kind_e;

endpackage

/* source/sc_retire_compare.sv */
// Two-stage retirement field compare with sticky first mismatch and pair counter
`timescale 1ns/1ps
`include "sc_macros.svh"

module sc_retire_compare (
   input  logic                 clknrst_if,
   input  logic                 rst_n_i,
   input  logic                 pair_valid_i,
   input  logic [`SC_XLEN-1:0]  dut_pc_i,
   input  logic                 dut_we_i,
   input  logic [4:0]           dut_rd_i,
   input  logic [`SC_XLEN-1:0]  dut_wdata_i,
   input  logic [`SC_XLEN-1:0]  ref_pc_i,
   input  logic                 ref_we_i,
   input  logic [4:0]           ref_rd_i,
   input  logic [`SC_XLEN-1:0]  ref_wdata_i,
   output logic                 mismatch_o,
   output logic                 cmp_valid_o,
   output logic [`SC_CNT_W-1:0] cmp_cnt_o,
   output logic                 mis_valid_o,
   output sc_pkg::sc_mis_kind_e mis_kind_o,
   output logic [`SC_XLEN-1:0]  mis_pc_o,
   output logic [`SC_XLEN-1:0]  mis_exp_o,
   output logic [`SC_XLEN-1:0]  mis_act_o
);

   import sc_pkg::*;

   logic                 both_we;
   // Stage 1 match flags and the fields needed for reporting
   logic                 s1_valid_q;
   logic                 s1_pc_mis_q;
   logic                 s1_we_mis_q;
   logic                 s1_rd_mis_q;
   logic                 s1_wd_mis_q;
   logic [`SC_XLEN-1:0]  s1_ref_pc_q;
   logic [`SC_XLEN-1:0]  s1_dut_pc_q;
   logic                 s1_ref_we_q;
   logic                 s1_dut_we_q;
   logic [4:0]           s1_ref_rd_q;
   logic [4:0]           s1_dut_rd_q;
   logic [`SC_XLEN-1:0]  s1_ref_wd_q;
   logic [`SC_XLEN-1:0]  s1_dut_wd_q;
   // Stage 2 decision
   sc_mis_kind_e         kind_d;
   logic [`SC_XLEN-1:0]  exp_d;
   logic [`SC_XLEN-1:0]  act_d;
   logic                 first_mis;
   // Result and sticky record
   logic                 cmp_valid_q;
   logic                 mismatch_q;
   logic [`SC_CNT_W-1:0] cmp_cnt_q;
   logic                 mis_valid_q;
   sc_mis_kind_e         mis_kind_q;
   logic [`SC_XLEN-1:0]  mis_pc_q;
   logic [`SC_XLEN-1:0]  mis_exp_q;
   logic [`SC_XLEN-1:0]  mis_act_q;

   // Register and data only matter when both sides write
   assign both_we = dut_we_i && ref_we_i;

   always_ff @(posedge clknrst_if or negedge rst_n_i) begin
      if (!rst_n_i) begin
         s1_valid_q <= 1'b0;
      end else begin
         s1_valid_q <= pair_valid_i;
      end
   end

   always_ff @(posedge clknrst_if) begin
      s1_pc_mis_q <= (dut_pc_i != ref_pc_i);
      s1_we_mis_q <= (dut_we_i != ref_we_i);
      s1_rd_mis_q <= both_we && (dut_rd_i != ref_rd_i);
      // Data written to x0 is discarded by the core
      s1_wd_mis_q <= both_we && (ref_rd_i != 5'd0) && (dut_wdata_i != ref_wdata_i);
      s1_ref_pc_q <= ref_pc_i;
      s1_dut_pc_q <= dut_pc_i;
      s1_ref_we_q <= ref_we_i;
      s1_dut_we_q <= dut_we_i;
      s1_ref_rd_q <= ref_rd_i;
      s1_dut_rd_q <= dut_rd_i;
      s1_ref_wd_q <= ref_wdata_i;
      s1_dut_wd_q <= dut_wdata_i;
   end

   // Priority PC, write-enable, register, data
   // Expected values come from the reference side and actual values from the core under test
   always_comb begin
      kind_d = MIS_NONE;
      exp_d  = '0;
      act_d  = '0;
      if (s1_pc_mis_q) begin
         kind_d = MIS_PC;
         exp_d  = s1_ref_pc_q;
         act_d  = s1_dut_pc_q;
      end else if (s1_we_mis_q) begin
         kind_d = MIS_WE;
         exp_d  = {{(`SC_XLEN-1){1'b0}}, s1_ref_we_q};
         act_d  = {{(`SC_XLEN-1){1'b0}}, s1_dut_we_q};
      end else if (s1_rd_mis_q) begin
         kind_d = MIS_RD;
         exp_d  = {{(`SC_XLEN-5){1'b0}}, s1_ref_rd_q};
         act_d  = {{(`SC_XLEN-5){1'b0}}, s1_dut_rd_q};
      end else if (s1_wd_mis_q) begin
         kind_d = MIS_WDATA;
         exp_d  = s1_ref_wd_q;
         act_d  = s1_dut_wd_q;
      end
   end

   // Only the first failing pair is recorded
   assign first_mis = s1_valid_q && (kind_d != MIS_NONE) && !mis_valid_q;

   always_ff @(posedge clknrst_if or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cmp_valid_q <= 1'b0;
         mismatch_q  <= 1'b0;
         cmp_cnt_q   <= '0;
         mis_valid_q <= 1'b0;
         mis_kind_q  <= MIS_NONE;
         mis_pc_q    <= '0;
         mis_exp_q   <= '0;
         mis_act_q   <= '0;
      end else begin
         cmp_valid_q <= s1_valid_q;
         mismatch_q  <= first_mis;
         if (s1_valid_q) begin
            cmp_cnt_q <= cmp_cnt_q + 1'b1;
         end
         if (first_mis) begin
            mis_valid_q <= 1'b1;
            mis_kind_q  <= kind_d;
            mis_pc_q    <= s1_ref_pc_q;
            mis_exp_q   <= exp_d;
            mis_act_q   <= act_d;
         end
      end
   end

   assign mismatch_o  = mismatch_q;
   assign cmp_valid_o = cmp_valid_q;
   assign cmp_cnt_o   = cmp_cnt_q;
   assign mis_valid_o = mis_valid_q;
   assign mis_kind_o  = mis_kind_q;
   assign mis_pc_o    = mis_pc_q;
   assign mis_exp_o   = mis_exp_q;
   assign mis_act_o   = mis_act_q;

   // Scheduler has halted once a mismatch is on record, so no new pair arrives
   a_no_pair_after_mis: assert property (
      @(posedge clknrst_if) disable iff (!rst_n_i) mis_valid_o |-> !pair_valid_i);

endmodule

/* source/sc_retire_fifo.sv */
// Retirement record FIFO that returns one credit to its producer per pop
`timescale 1ns/1ps
`include "sc_macros.svh"

module sc_retire_fifo (
   input  logic                clknrst_if,
   input  logic                rst_n_i,
   input  logic                push_i,
   input  logic [`SC_XLEN-1:0] pc_i,
   input  logic                we_i,
   input  logic [4:0]          rd_i,
   input  logic [`SC_XLEN-1:0] wdata_i,
   input  logic                exc_i,
   input  logic                pop_i,
   output logic                not_empty_o,
   output logic [`SC_XLEN-1:0] head_pc_o,
   output logic                head_we_o,
   output logic [4:0]          head_rd_o,
   output logic [`SC_XLEN-1:0] head_wdata_o,
   output logic                head_exc_o,
   output logic                credit_o
);

   localparam int PTR_W = $clog2(`SC_FIFO_DEPTH);
   // Record layout is {pc, we, rd, wdata, exc}
   localparam int REC_W = 2 * `SC_XLEN + 7;
   localparam logic [`SC_CREDIT_W-1:0] FULL_CNT = `SC_FIFO_DEPTH;

   logic [REC_W-1:0]        mem [`SC_FIFO_DEPTH];
   logic [PTR_W-1:0]        wr_ptr_q;
   logic [PTR_W-1:0]        rd_ptr_q;
   logic [`SC_CREDIT_W-1:0] count_q;
   logic                    credit_q;

   // Storage, written on push only
   always_ff @(posedge clknrst_if) begin
      if (push_i) begin
         mem[wr_ptr_q] <= {pc_i, we_i, rd_i, wdata_i, exc_i};
      end
   end

   // Pointers wrap on their own since the depth is a power of two
   always_ff @(posedge clknrst_if or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
         credit_q <= 1'b0;
      end else begin
         if (push_i) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop_i) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({push_i, pop_i})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
         // Credit goes back one cycle after the record leaves
         credit_q <= pop_i;
      end
   end

   assign not_empty_o = (count_q != '0);
   assign {head_pc_o, head_we_o, head_rd_o, head_wdata_o, head_exc_o} = mem[rd_ptr_q];
   assign credit_o    = credit_q;

   // Producer broke the credit rule
   a_no_push_full: assert property (
      @(posedge clknrst_if) disable iff (!rst_n_i) push_i |-> (count_q != FULL_CNT));

   // Scheduler popped a record that was never pushed
   a_no_pop_empty: assert property (
      @(posedge clknrst_if) disable iff (!rst_n_i) pop_i |-> not_empty_o);

endmodule

/* source/sc_step_compare_top.sv */
// Lockstep retirement checker top with two record FIFOs, the step scheduler and the comparator
`timescale 1ns/1ps
`include "sc_macros.svh"

module sc_step_compare_top (
   input  logic                 clknrst_if,
   input  logic                 rst_n_i,
   // Core under test retirement stream
   input  logic                 dut_valid_i,
   input  logic [`SC_XLEN-1:0]  dut_pc_i,
   input  logic                 dut_we_i,
   input  logic [4:0]           dut_rd_i,
   input  logic [`SC_XLEN-1:0]  dut_wdata_i,
   input  logic                 dut_exc_i,
   // Reference model retirement stream
   input  logic                 ref_valid_i,
   input  logic [`SC_XLEN-1:0]  ref_pc_i,
   input  logic                 ref_we_i,
   input  logic [4:0]           ref_rd_i,
   input  logic [`SC_XLEN-1:0]  ref_wdata_i,
   input  logic                 ref_exc_i,
   output logic                 dut_credit_o,
   output logic                 ref_credit_o,
   output logic                 dut_step_o,
   output logic                 ref_step_o,
   output logic                 halt_o,
   output logic                 cmp_valid_o,
   output logic [`SC_CNT_W-1:0] cmp_cnt_o,
   output logic [`SC_CNT_W-1:0] dut_exc_cnt_o,
   output logic [`SC_CNT_W-1:0] ref_exc_cnt_o,
   output logic                 mis_valid_o,
   output sc_pkg::sc_mis_kind_e mis_kind_o,
   output logic [`SC_XLEN-1:0]  mis_pc_o,
   output logic [`SC_XLEN-1:0]  mis_exp_o,
   output logic [`SC_XLEN-1:0]  mis_act_o
);

   // FIFO heads toward scheduler and comparator
   logic                dut_not_empty;
   logic [`SC_XLEN-1:0] dut_head_pc;
   logic                dut_head_we;
   logic [4:0]          dut_head_rd;
   logic [`SC_XLEN-1:0] dut_head_wdata;
   logic                dut_head_exc;
   logic                dut_pop;
   logic                ref_not_empty;
   logic [`SC_XLEN-1:0] ref_head_pc;
   logic                ref_head_we;
   logic [4:0]          ref_head_rd;
   logic [`SC_XLEN-1:0] ref_head_wdata;
   logic                ref_head_exc;
   logic                ref_pop;
   // Scheduler and comparator handshake
   logic                pair_valid;
   logic                mismatch;

   sc_retire_fifo i_dut_fifo (
      .clknrst_if   (clknrst_if),
      .rst_n_i      (rst_n_i),
      .push_i       (dut_valid_i),
      .pc_i         (dut_pc_i),
      .we_i         (dut_we_i),
      .rd_i         (dut_rd_i),
      .wdata_i      (dut_wdata_i),
      .exc_i        (dut_exc_i),
      .pop_i        (dut_pop),
      .not_empty_o  (dut_not_empty),
      .head_pc_o    (dut_head_pc),
      .head_we_o    (dut_head_we),
      .head_rd_o    (dut_head_rd),
      .head_wdata_o (dut_head_wdata),
      .head_exc_o   (dut_head_exc),
      .credit_o     (dut_credit_o)
   );

   sc_retire_fifo i_ref_fifo (
      .clknrst_if   (clknrst_if),
      .rst_n_i      (rst_n_i),
      .push_i       (ref_valid_i),
      .pc_i         (ref_pc_i),
      .we_i         (ref_we_i),
      .rd_i         (ref_rd_i),
      .wdata_i      (ref_wdata_i),
      .exc_i        (ref_exc_i),
      .pop_i        (ref_pop),
      .not_empty_o  (ref_not_empty),
      .head_pc_o    (ref_head_pc),
      .head_we_o    (ref_head_we),
      .head_rd_o    (ref_head_rd),
      .head_wdata_o (ref_head_wdata),
      .head_exc_o   (ref_head_exc),
      .credit_o     (ref_credit_o)
   );

   sc_step_sched i_sched (
      .clknrst_if      (clknrst_if),
      .rst_n_i         (rst_n_i),
      .dut_not_empty_i (dut_not_empty),
      .dut_exc_i       (dut_head_exc),
      .ref_not_empty_i (ref_not_empty),
      .ref_exc_i       (ref_head_exc),
      .mismatch_i      (mismatch),
      .dut_pop_o       (dut_pop),
      .ref_pop_o       (ref_pop),
      .pair_valid_o    (pair_valid),
      .dut_step_o      (dut_step_o),
      .ref_step_o      (ref_step_o),
      .halt_o          (halt_o),
      .dut_exc_cnt_o   (dut_exc_cnt_o),
      .ref_exc_cnt_o   (ref_exc_cnt_o)
   );

   sc_retire_compare i_cmp (
      .clknrst_if   (clknrst_if),
      .rst_n_i      (rst_n_i),
      .pair_valid_i (pair_valid),
      .dut_pc_i     (dut_head_pc),
      .dut_we_i     (dut_head_we),
      .dut_rd_i     (dut_head_rd),
      .dut_wdata_i  (dut_head_wdata),
      .ref_pc_i     (ref_head_pc),
      .ref_we_i     (ref_head_we),
      .ref_rd_i     (ref_head_rd),
      .ref_wdata_i  (ref_head_wdata),
      .mismatch_o   (mismatch),
      .cmp_valid_o  (cmp_valid_o),
      .cmp_cnt_o    (cmp_cnt_o),
      .mis_valid_o  (mis_valid_o),
      .mis_kind_o   (mis_kind_o),
      .mis_pc_o     (mis_pc_o),
      .mis_exp_o    (mis_exp_o),
      .mis_act_o    (mis_act_o)
   );

endmodule

/* source/sc_step_sched.sv */
// Step scheduler FSM that drops exceptions, pops record pairs and halts on mismatch
`timescale 1ns/1ps
`include "sc_macros.svh"

module sc_step_sched (
   input  logic                 clknrst_if,
   input  logic                 rst_n_i,
   input  logic                 dut_not_empty_i,
   input  logic                 dut_exc_i,
   input  logic                 ref_not_empty_i,
   input  logic                 ref_exc_i,
   input  logic                 mismatch_i,
   output logic                 dut_pop_o,
   output logic                 ref_pop_o,
   output logic                 pair_valid_o,
   output logic                 dut_step_o,
   output logic                 ref_step_o,
   output logic                 halt_o,
   output logic [`SC_CNT_W-1:0] dut_exc_cnt_o,
   output logic [`SC_CNT_W-1:0] ref_exc_cnt_o
);

   import sc_pkg::*;

   sc_state_e            state_q;
   sc_state_e            state_d;
   logic                 dut_drop;
   logic                 ref_drop;
   logic [`SC_CNT_W-1:0] dut_exc_cnt_q;
   logic [`SC_CNT_W-1:0] ref_exc_cnt_q;

   // Exception at the head of the stream being stepped is popped in place
   assign dut_drop = (state_q == STEP_DUT) && dut_not_empty_i && dut_exc_i;
   assign ref_drop = (state_q == STEP_REF) && ref_not_empty_i && ref_exc_i;

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            state_d = STEP_DUT;
         end
         // Wait for a normal DUT retirement, it stays at the head
         STEP_DUT: begin
            if (dut_not_empty_i && !dut_exc_i) begin
               state_d = STEP_REF;
            end
         end
         // Same for the reference side
         STEP_REF: begin
            if (ref_not_empty_i && !ref_exc_i) begin
               state_d = COMPARE;
            end
         end
         COMPARE: begin
            state_d = STEP_DUT;
         end
         default: begin
            state_d = HALT;
         end
      endcase
      // Any mismatch stops stepping until reset
      if (mismatch_i) begin
         state_d = HALT;
      end
   end

   always_ff @(posedge clknrst_if or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q       <= IDLE;
         dut_exc_cnt_q <= '0;
         ref_exc_cnt_q <= '0;
      end else begin
         state_q <= state_d;
         if (dut_drop) begin
            dut_exc_cnt_q <= dut_exc_cnt_q + 1'b1;
         end
         if (ref_drop) begin
            ref_exc_cnt_q <= ref_exc_cnt_q + 1'b1;
         end
      end
   end

   // COMPARE retires both heads at once
   assign pair_valid_o  = (state_q == COMPARE);
   assign dut_pop_o     = dut_drop || pair_valid_o;
   assign ref_pop_o     = ref_drop || pair_valid_o;

   assign dut_step_o    = (state_q == STEP_DUT);
   assign ref_step_o    = (state_q == STEP_REF);
   assign halt_o        = (state_q == HALT);
   assign dut_exc_cnt_o = dut_exc_cnt_q;
   assign ref_exc_cnt_o = ref_exc_cnt_q;

   // A pair is only formed from two records already held in the FIFOs
   a_pair_has_heads: assert property (
      @(posedge clknrst_if) disable iff (!rst_n_i)
      pair_valid_o |-> (dut_not_empty_i && ref_not_empty_i));

endmodule

/* tb.f */
+incdir+include
source/sc_pkg.sv
source/sc_retire_fifo.sv
source/sc_step_sched.sv
source/sc_retire_compare.sv
source/sc_step_compare_top.sv
verif/sc_tb_checker.sv
verif/sc_tb_top.sv

/* verif/sc_tb_checker.sv */
// Testbench checker with record pair model, result prediction, value checks and test reports
`timescale 1ns/1ps
`include "sc_macros.svh"

module sc_tb_checker (
   input  logic                 clknrst_if,
   input  logic                 rst_n_i,
   input  logic                 cmp_valid_i,
   input  logic [`SC_CNT_W-1:0] cmp_cnt_i,
   input  logic                 mis_valid_i,
   input  sc_pkg::sc_mis_kind_e mis_kind_i,
   input  logic [`SC_XLEN-1:0]  mis_pc_i,
   input  logic [`SC_XLEN-1:0]  mis_exp_i,
   input  logic [`SC_XLEN-1:0]  mis_act_i
);

   import sc_pkg::*;

   // Same {pc, we, rd, wdata, exc} layout as the producers
   localparam int REC_W  = 2 * `SC_XLEN + 7;
   localparam int PC_LSB = `SC_XLEN + 7;
   localparam int WE_BIT = `SC_XLEN + 6;
   localparam int RD_LSB = `SC_XLEN + 1;

   // Normal record pairs in retirement order
   logic [REC_W-1:0]    dut_q [$];
   logic [REC_W-1:0]    ref_q [$];
   int                  err_cnt;
   int                  test_cnt;
   int                  test_fail_cnt;
   int                  test_err_base;
   int                  model_cnt;
   string               test_name;
   // First predicted mismatch, sticky like the DUT record
   logic                exp_mis;
   sc_mis_kind_e        exp_kind;
   logic [`SC_XLEN-1:0] exp_pc;
   logic [`SC_XLEN-1:0] exp_exp;
   logic [`SC_XLEN-1:0] exp_act;
   logic [REC_W-1:0]    d_rec;
   logic [REC_W-1:0]    r_rec;
   sc_mis_kind_e        kind;
   logic [`SC_XLEN-1:0] ev;
   logic [`SC_XLEN-1:0] av;

   task check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         err_cnt++;
         $display("error at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      end
   endtask

   task report_failure(input string what);
      err_cnt++;
      $display("failure at %0t ns: %s", $time, what);
   endtask

   task start_test(input string name);
      dut_q.delete();
      ref_q.delete();
      model_cnt     = 0;
      exp_mis       = 1'b0;
      test_name     = name;
      test_err_base = err_cnt;
   endtask

   task end_test();
      test_cnt++;
      if (err_cnt > test_err_base) begin
         test_fail_cnt++;
         $display("test %s: failed with %0d errors", test_name, err_cnt - test_err_base);
      end else begin
         $display("test %s: ok", test_name);
      end
   endtask

   task add_pair(input logic [REC_W-1:0] d, input logic [REC_W-1:0] r);
      dut_q.push_back(d);
      ref_q.push_back(r);
   endtask

   task report_counts();
      $display("%0d tests run, %0d failed, %0d errors in total", test_cnt, test_fail_cnt, err_cnt);
   endtask

   // Priority PC, write-enable, register, data; expected from reference, actual from DUT
   task predict(input logic [REC_W-1:0] d, input logic [REC_W-1:0] r,
                output sc_mis_kind_e k, output logic [`SC_XLEN-1:0] e,
                output logic [`SC_XLEN-1:0] a);
      logic both_we;
      both_we = d[WE_BIT] && r[WE_BIT];
      k = MIS_NONE;
      e = '0;
      a = '0;
      if (d[PC_LSB +: `SC_XLEN] != r[PC_LSB +: `SC_XLEN]) begin
         k = MIS_PC;
         e = r[PC_LSB +: `SC_XLEN];
         a = d[PC_LSB +: `SC_XLEN];
      end else if (d[WE_BIT] != r[WE_BIT]) begin
         k = MIS_WE;
         e = r[WE_BIT];
         a = d[WE_BIT];
      end else if (both_we && d[RD_LSB +: 5] != r[RD_LSB +: 5]) begin
         k = MIS_RD;
         e = r[RD_LSB +: 5];
         a = d[RD_LSB +: 5];
      end else if (both_we && r[RD_LSB +: 5] != 5'd0 &&
                   d[1 +: `SC_XLEN] != r[1 +: `SC_XLEN]) begin
         // Writes to x0 never count
         k = MIS_WDATA;
         e = r[1 +: `SC_XLEN];
         a = d[1 +: `SC_XLEN];
      end
   endtask

   // One model pair retires per result pulse
   always @(negedge clknrst_if) begin
      if (rst_n_i && cmp_valid_i) begin
         if (dut_q.size() == 0 || ref_q.size() == 0) begin
            report_failure("comparison result arrived with no record pair left in the model");
         end else begin
            d_rec = dut_q.pop_front();
            r_rec = ref_q.pop_front();
            model_cnt++;
            predict(d_rec, r_rec, kind, ev, av);
            if (!exp_mis && kind != MIS_NONE) begin
               exp_mis  = 1'b1;
               exp_kind = kind;
               exp_pc   = r_rec[PC_LSB +: `SC_XLEN];
               exp_exp  = ev;
               exp_act  = av;
            end
            check_eq("cmp_cnt_o", cmp_cnt_i, model_cnt);
            check_eq("mis_valid_o", mis_valid_i, exp_mis);
            if (exp_mis) begin
               check_eq("mis_kind_o", mis_kind_i, exp_kind);
               check_eq("mis_pc_o", mis_pc_i, exp_pc);
               check_eq("mis_exp_o", mis_exp_i, exp_exp);
               check_eq("mis_act_o", mis_act_i, exp_act);
            end
         end
      end
   end

endmodule

/* verif/sc_tb_top.sv */
// Testbench top with clock, reset, seeded credit-based producers, DUT instance and test sequence
`timescale 1ns/1ps
`include "sc_macros.svh"

module sc_tb_top;

   import sc_pkg::*;

   // Producer record layout {pc, we, rd, wdata, exc}
   localparam int REC_W   = 2 * `SC_XLEN + 7;
   localparam int PC_LSB  = `SC_XLEN + 7;
   localparam int WE_BIT  = `SC_XLEN + 6;
   localparam int RD_LSB  = `SC_XLEN + 1;
   localparam int TIMEOUT = 20000;

   logic                 clknrst_if = 1'b0;
   logic                 rst_n;
   logic                 dut_valid;
   logic                 ref_valid;
   logic [REC_W-1:0]     dut_rec;
   logic [REC_W-1:0]     ref_rec;
   logic                 dut_credit;
   logic                 ref_credit;
   logic                 dut_step;
   logic                 ref_step;
   logic                 halt;
   logic                 cmp_valid;
   logic [`SC_CNT_W-1:0] cmp_cnt;
   logic [`SC_CNT_W-1:0] dut_exc_cnt;
   logic [`SC_CNT_W-1:0] ref_exc_cnt;
   logic                 mis_valid;
   sc_mis_kind_e         mis_kind;
   logic [`SC_XLEN-1:0]  mis_pc;
   logic [`SC_XLEN-1:0]  mis_exp;
   logic [`SC_XLEN-1:0]  mis_act;
   // Records still to be sent including exceptions
   logic [REC_W-1:0]     dut_q [$];
   logic [REC_W-1:0]     ref_q [$];
   int                   dut_credits;
   int                   ref_credits;
   int                   dut_gap;
   int                   ref_gap;
   int                   dut_exc_exp;
   int                   ref_exc_exp;
   logic                 burst_mode;
   integer               seed;
   // Fires once per falling edge after the producers have driven
   event                 tick;

   sc_step_compare_top i_dut (
      .clknrst_if (clknrst_if), .rst_n_i (rst_n),
      .dut_valid_i (dut_valid), .dut_pc_i (dut_rec[PC_LSB +: `SC_XLEN]),
      .dut_we_i (dut_rec[WE_BIT]), .dut_rd_i (dut_rec[RD_LSB +: 5]),
      .dut_wdata_i (dut_rec[1 +: `SC_XLEN]), .dut_exc_i (dut_rec[0]),
      .ref_valid_i (ref_valid), .ref_pc_i (ref_rec[PC_LSB +: `SC_XLEN]),
      .ref_we_i (ref_rec[WE_BIT]), .ref_rd_i (ref_rec[RD_LSB +: 5]),
      .ref_wdata_i (ref_rec[1 +: `SC_XLEN]), .ref_exc_i (ref_rec[0]),
      .dut_credit_o (dut_credit), .ref_credit_o (ref_credit),
      .dut_step_o (dut_step), .ref_step_o (ref_step), .halt_o (halt),
      .cmp_valid_o (cmp_valid), .cmp_cnt_o (cmp_cnt),
      .dut_exc_cnt_o (dut_exc_cnt), .ref_exc_cnt_o (ref_exc_cnt),
      .mis_valid_o (mis_valid), .mis_kind_o (mis_kind), .mis_pc_o (mis_pc),
      .mis_exp_o (mis_exp), .mis_act_o (mis_act)
   );

   sc_tb_checker i_chk (
      .clknrst_if (clknrst_if), .rst_n_i (rst_n), .cmp_valid_i (cmp_valid),
      .cmp_cnt_i (cmp_cnt), .mis_valid_i (mis_valid), .mis_kind_i (mis_kind),
      .mis_pc_i (mis_pc), .mis_exp_i (mis_exp), .mis_act_i (mis_act)
   );

   initial begin
      forever #10 clknrst_if = ~clknrst_if;
   end

   // Short gaps or bursts broken by long pauses
   function int next_gap();
      logic [31:0] r;
      r = $random(seed);
      if (!burst_mode) begin
         next_gap = r[1:0];
      end else begin
         next_gap = (r[3:0] < 4'd11) ? 0 : r[9:4];
      end
   endfunction

   function logic [REC_W-1:0] make_rec(input logic [`SC_XLEN-1:0] pc, input logic we,
                                       input logic [4:0] rd, input logic [`SC_XLEN-1:0] wd,
                                       input logic exc);
      make_rec = {pc, we, rd, wd, exc};
   endfunction

   // Both producers spend one credit per sent record and regain it on each credit pulse
   always @(negedge clknrst_if) begin
      if (!rst_n) begin
         dut_valid   = 1'b0;
         ref_valid   = 1'b0;
         dut_credits = `SC_FIFO_DEPTH;
         ref_credits = `SC_FIFO_DEPTH;
         dut_gap     = 0;
         ref_gap     = 0;
      end else begin
         dut_credits = dut_credits + dut_credit;
         ref_credits = ref_credits + ref_credit;
         dut_valid   = 1'b0;
         ref_valid   = 1'b0;
         if (dut_gap > 0) begin
            dut_gap = dut_gap - 1;
         end else if (dut_q.size() > 0 && dut_credits > 0) begin
            dut_rec     = dut_q.pop_front();
            dut_valid   = 1'b1;
            dut_credits = dut_credits - 1;
            dut_gap     = next_gap();
         end
         if (ref_gap > 0) begin
            ref_gap = ref_gap - 1;
         end else if (ref_q.size() > 0 && ref_credits > 0) begin
            ref_rec     = ref_q.pop_front();
            ref_valid   = 1'b1;
            ref_credits = ref_credits - 1;
            ref_gap     = next_gap();
         end
      end
      -> tick;
   end

   task timeout_abort(input string what);
      $display("timeout: %s", what);
      $display("SIMULATION FAILED");
      $finish;
   endtask

   task wait_ticks(input int n);
      for (int i = 0; i < n; i++) begin
         @(tick);
      end
   endtask

   task apply_reset();
      rst_n = 1'b0;
      dut_q.delete();
      ref_q.delete();
      dut_exc_exp = 0;
      ref_exc_exp = 0;
      wait_ticks(5);
      rst_n = 1'b1;
   endtask

   // Pairs with random exceptions ahead of them and an optional fault in one pair
   task gen_pairs(input int n, input int exc_lvl, input sc_mis_kind_e inject,
                  input int inject_at, input logic r0_only);
      logic [31:0]         r;
      logic [`SC_XLEN-1:0] pc;
      logic [`SC_XLEN-1:0] wd;
      logic [`SC_XLEN-1:0] r_pc;
      logic [`SC_XLEN-1:0] r_wd;
      logic                we;
      logic                r_we;
      logic [4:0]          rd;
      logic [4:0]          r_rd;
      for (int i = 0; i < n; i++) begin
         r = $random(seed);
         if (r[6:0] < exc_lvl) begin
            dut_q.push_back(make_rec($random(seed), r[7], r[12:8], $random(seed), 1'b1));
            dut_exc_exp++;
         end
         if (r[22:16] < exc_lvl) begin
            ref_q.push_back(make_rec($random(seed), r[23], r[28:24], $random(seed), 1'b1));
            ref_exc_exp++;
         end
         r  = $random(seed);
         pc = $random(seed);
         wd = $random(seed);
         we = r[0] | r0_only;
         rd = r0_only ? 5'd0 : r[5:1];
         // Register and data faults only show when both sides write a real register
         if (i == inject_at && (inject == MIS_RD || inject == MIS_WDATA)) begin
            we = 1'b1;
            rd = rd | 5'd1;
         end
         r_pc = pc;
         r_we = we;
         r_rd = rd;
         r_wd = r0_only ? ~wd : wd;
         if (i == inject_at) begin
            case (inject)
               MIS_PC:    r_pc = pc ^ 'h10;
               MIS_WE:    r_we = ~we;
               MIS_RD:    r_rd = rd ^ 5'h2;
               MIS_WDATA: r_wd = ~wd;
               default:   r_pc = pc;
            endcase
         end
         dut_q.push_back(make_rec(pc, we, rd, wd, 1'b0));
         ref_q.push_back(make_rec(r_pc, r_we, r_rd, r_wd, 1'b0));
         i_chk.add_pair(make_rec(pc, we, rd, wd, 1'b0), make_rec(r_pc, r_we, r_rd, r_wd, 1'b0));
      end
   endtask

   // Last credit pulse lands one cycle before the last count update
   task wait_drain(input int n);
      int cyc;
      cyc = 0;
      while (!(dut_q.size() == 0 && ref_q.size() == 0 && cmp_cnt >= n)) begin
         @(tick);
         cyc++;
         if (cyc > TIMEOUT) timeout_abort("streams did not drain");
      end
   endtask

   task wait_halt();
      int cyc;
      cyc = 0;
      while (!halt) begin
         @(tick);
         cyc++;
         if (cyc > TIMEOUT) timeout_abort("halt_o never rose after the injected mismatch");
      end
   endtask

   task check_reset_outputs();
      i_chk.check_eq("cmp_valid_o", cmp_valid, 0);
      i_chk.check_eq("mis_valid_o", mis_valid, 0);
      i_chk.check_eq("mis_kind_o", mis_kind, MIS_NONE);
      i_chk.check_eq("halt_o", halt, 0);
      i_chk.check_eq("dut_step_o", dut_step, 0);
      i_chk.check_eq("ref_step_o", ref_step, 0);
      i_chk.check_eq("dut_credit_o", dut_credit, 0);
      i_chk.check_eq("ref_credit_o", ref_credit, 0);
      i_chk.check_eq("cmp_cnt_o", cmp_cnt, 0);
      i_chk.check_eq("dut_exc_cnt_o", dut_exc_cnt, 0);
      i_chk.check_eq("ref_exc_cnt_o", ref_exc_cnt, 0);
   endtask

   task run_clean(input string name, input int n, input int exc_lvl, input logic r0_only,
                  input logic burst);
      i_chk.start_test(name);
      apply_reset();
      burst_mode = burst;
      gen_pairs(n, exc_lvl, MIS_NONE, -1, r0_only);
      wait_drain(n);
      i_chk.check_eq("cmp_cnt_o", cmp_cnt, n);
      i_chk.check_eq("mis_valid_o", mis_valid, 0);
      i_chk.check_eq("halt_o", halt, 0);
      i_chk.check_eq("dut_exc_cnt_o", dut_exc_cnt, dut_exc_exp);
      i_chk.check_eq("ref_exc_cnt_o", ref_exc_cnt, ref_exc_exp);
      // Drained scheduler waits for the next core retirement
      i_chk.check_eq("dut_step_o", dut_step, 1);
      i_chk.check_eq("ref_step_o", ref_step, 0);
      i_chk.check_eq("dut producer credits", dut_credits, `SC_FIFO_DEPTH);
      i_chk.check_eq("ref producer credits", ref_credits, `SC_FIFO_DEPTH);
      i_chk.end_test();
   endtask

   task run_mismatch(input string name, input sc_mis_kind_e kind);
      logic [31:0] r;
      int          at;
      int          cnt_halt;
      int          cnt_late;
      i_chk.start_test(name);
      apply_reset();
      burst_mode = 1'b0;
      r  = $random(seed);
      at = 5 + r[3:0];
      gen_pairs(40, 10, kind, at, 1'b0);
      wait_halt();
      cnt_halt = cmp_cnt;
      wait_ticks(10);
      cnt_late = cmp_cnt;
      if (cnt_late > cnt_halt + 1) begin
         i_chk.report_failure("cmp_cnt_o grew by more than one after halt_o");
      end
      if (cnt_late != at + 1 && cnt_late != at + 2) begin
         i_chk.report_failure($sformatf("cmp_cnt_o stopped at %0d, mismatch was pair %0d",
                                        cnt_late, at + 1));
      end
      // Halted checker must stay frozen
      wait_ticks(10);
      i_chk.check_eq("cmp_cnt_o", cmp_cnt, cnt_late);
      i_chk.check_eq("mis_valid_o", mis_valid, 1);
      i_chk.check_eq("mis_kind_o", mis_kind, kind);
      i_chk.check_eq("halt_o", halt, 1);
      i_chk.check_eq("dut_step_o", dut_step, 0);
      i_chk.check_eq("ref_step_o", ref_step, 0);
      i_chk.end_test();
   endtask

   initial begin
      seed       = 96;
      rst_n      = 1'b0;
      dut_valid  = 1'b0;
      ref_valid  = 1'b0;
      dut_rec    = '0;
      ref_rec    = '0;
      burst_mode = 1'b0;
      i_chk.start_test("reset");
      apply_reset();
      check_reset_outputs();
      i_chk.end_test();
      run_clean("matching streams", 200, 0, 1'b0, 1'b0);
      run_clean("exceptions", 120, 32, 1'b0, 1'b0);
      run_clean("register 0 writes", 60, 0, 1'b1, 1'b0);
      run_mismatch("pc mismatch", MIS_PC);
      run_mismatch("write-enable mismatch", MIS_WE);
      run_mismatch("register mismatch", MIS_RD);
      run_mismatch("write data mismatch", MIS_WDATA);
      run_clean("flow control bursts", 200, 16, 1'b0, 1'b1);
      i_chk.report_counts();
      if (i_chk.err_cnt == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule
